//--- hdl/rx_emu_pkg.sv
package rx_emu_pkg;

    // slice organisation
    localparam int n_slices    = 16;  // total adc slices
    localparam int n_lanes     = 4;   // slices sharing one pi code
    localparam int n_pi_groups = 4;   // number of pi codes
    localparam int pi_width    = 9;
    localparam int adc_width   = 8;   // magnitude bits

    // received bit history and chunking
    localparam int hist_width  = 32;  // bit 31 is the newest bit
    localparam int chunk_width = 8;
    localparam int n_chunks    = 4;   // hist_width / chunk_width

    // channel model
    localparam int n_taps    = 8;
    localparam int tap_width = 8;
    localparam int sum_width = 10;    // signed, holds +/-188 with margin

    // tap 0 weights the newest bit of the window
    localparam logic signed [tap_width-1:0] chan_taps [n_taps] = '{
        8'sd10,
        8'sd90,
        8'sd40,
        -8'sd20,
        8'sd12,
        -8'sd8,
        8'sd5,
        -8'sd3
    };

    // coarse whole-bit delay sits in the top two bits of a pi code
    localparam int pi_delay_lsb = 7;

    // six-cycle frame
    typedef enum logic [2:0] {
        ph_chunk0,  // accumulate chunk 0, clears slice sums
        ph_chunk1,
        ph_chunk2,
        ph_chunk3,
        ph_settle,  // hold
        ph_write    // outputs register, history loads
    } frame_phase_e;

endpackage

//--- hdl/frame_sequencer.sv
`timescale 1ns/1ns

module frame_sequencer (
    input  logic                                       emu_clk,
    input  logic                                       emu_rst,
    input  logic                                       ctl_valid,  // capture strobe for ctl_pi
    input  logic [rx_emu_pkg::pi_width-1:0]            ctl_pi [rx_emu_pkg::n_pi_groups],
    output logic [$clog2(rx_emu_pkg::n_chunks)-1:0]    chunk_idx,
    output logic                                       acc_en,     // high in chunk phases
    output logic                                       frame_end,  // high in ph_write
    output logic [rx_emu_pkg::pi_width-1:0]            pi_code [rx_emu_pkg::n_pi_groups]
);

    rx_emu_pkg::frame_phase_e phase;

    logic [rx_emu_pkg::pi_width-1:0] pi_shadow [rx_emu_pkg::n_pi_groups];  // latched ctl_pi

    // free running phase counter that wraps after ph_write
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            phase <= rx_emu_pkg::ph_chunk0;
        end else begin
            case (phase)
                rx_emu_pkg::ph_chunk0: phase <= rx_emu_pkg::ph_chunk1;
                rx_emu_pkg::ph_chunk1: phase <= rx_emu_pkg::ph_chunk2;
                rx_emu_pkg::ph_chunk2: phase <= rx_emu_pkg::ph_chunk3;
                rx_emu_pkg::ph_chunk3: phase <= rx_emu_pkg::ph_settle;
                rx_emu_pkg::ph_settle: phase <= rx_emu_pkg::ph_write;
                default:               phase <= rx_emu_pkg::ph_chunk0;  // ph_write
            endcase
        end
    end

    // chunk index only meaningful while accumulating
    always_comb begin
        case (phase)
            rx_emu_pkg::ph_chunk1: chunk_idx = 2'd1;
            rx_emu_pkg::ph_chunk2: chunk_idx = 2'd2;
            rx_emu_pkg::ph_chunk3: chunk_idx = 2'd3;
            default:               chunk_idx = 2'd0;
        endcase
    end

    assign acc_en    = (phase == rx_emu_pkg::ph_chunk0) ||
                       (phase == rx_emu_pkg::ph_chunk1) ||
                       (phase == rx_emu_pkg::ph_chunk2) ||
                       (phase == rx_emu_pkg::ph_chunk3);
    assign frame_end = (phase == rx_emu_pkg::ph_write);

    // shadow takes any valid write and the active copy moves only at a frame boundary
    // so a frame never sees two different codes
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            pi_shadow <= '{default: '0};
            pi_code   <= '{default: '0};
        end else begin
            if (ctl_valid) begin
                pi_shadow <= ctl_pi;
            end
            if (frame_end) begin
                pi_code <= pi_shadow;  // old shadow if ctl_valid hits the same edge
            end
        end
    end

    // slices rely on the next frame starting with a clearing chunk0
    a_write_then_chunk0: assert property (
        @(posedge emu_clk) disable iff (emu_rst)
        frame_end |=> (phase == rx_emu_pkg::ph_chunk0) && acc_en && (chunk_idx == 2'd0)
    );

endmodule

//--- hdl/bit_history.sv
`timescale 1ns/1ns

module bit_history (
    input  logic                                       emu_clk,
    input  logic                                       emu_rst,
    input  logic [rx_emu_pkg::hist_width/2-1:0]        rx_bits,    // newest 16 bits of a frame
    input  logic                                       frame_end,  // load strobe
    input  logic [$clog2(rx_emu_pkg::n_chunks)-1:0]    chunk_idx,
    output logic [rx_emu_pkg::chunk_width-1:0]         chunk
);

    localparam int half_width = rx_emu_pkg::hist_width / 2;

    logic [rx_emu_pkg::hist_width-1:0] history;  // [31:16] newest word and [15:0] previous word

    // one word per frame while the previous newest half slides down
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            history <= '0;
        end else if (frame_end) begin
            history <= {rx_bits, history[rx_emu_pkg::hist_width-1:half_width]};
        end
    end

    // chunk n covers bits 8n .. 8n+7
    assign chunk = history[rx_emu_pkg::chunk_width*chunk_idx +: rx_emu_pkg::chunk_width];

    // loads come a full frame apart so the four chunk reads of a frame see one snapshot
    a_history_frame_stable: assert property (
        @(posedge emu_clk) disable iff (emu_rst)
        frame_end |-> !$past(frame_end, 1) && !$past(frame_end, 2) && !$past(frame_end, 3)
                      && !$past(frame_end, 4) && !$past(frame_end, 5)
    );

endmodule

//--- hdl/adc_slice.sv
`timescale 1ns/1ns

module adc_slice (
    input  logic                                       emu_clk,
    input  logic                                       emu_rst,
    input  logic [rx_emu_pkg::chunk_width-1:0]         chunk,      // history bits of this cycle
    input  logic [$clog2(rx_emu_pkg::n_chunks)-1:0]    chunk_idx,
    input  logic                                       acc_en,
    input  logic                                       frame_end,  // register outputs
    input  logic [rx_emu_pkg::pi_width-1:0]            pi_code,    // active code of this group
    input  logic [$clog2(rx_emu_pkg::n_slices)-1:0]    slice_idx,  // position in the slice array
    output logic                                       out_sgn,    // 1 means negative
    output logic [rx_emu_pkg::adc_width-1:0]           out_mag
);

    localparam int sum_w = rx_emu_pkg::sum_width;

    logic [1:0]              lane_ofs;   // slice position inside its pi group
    logic [1:0]              grp_idx;    // which pi group
    logic [1:0]              pi_dly;     // coarse whole-bit delay from the code
    logic [5:0]              samp_pt;    // history index of the newest tapped bit
    logic signed [sum_w-1:0] chunk_sum;  // contribution of the current chunk
    logic signed [sum_w-1:0] acc;
    logic [sum_w-1:0]        abs_sum;

    assign lane_ofs = 2'(slice_idx % rx_emu_pkg::n_lanes);
    assign grp_idx  = 2'(slice_idx / rx_emu_pkg::n_lanes);
    assign pi_dly   = pi_code[rx_emu_pkg::pi_delay_lsb +: 2];

    // p = 16 + i - d, stays within 13..31 so the whole tap window is in the history
    assign samp_pt = 6'(rx_emu_pkg::hist_width / 2)
                   + 6'(grp_idx * rx_emu_pkg::n_lanes)
                   + 6'(lane_ofs)
                   - 6'(pi_dly);

    // bit j of the chunk is history bit b = 8*chunk_idx + j
    // it meets tap k = p - b when that k is a valid tap number
    always_comb begin
        int                      bit_pos;
        int                      tap_k;
        logic signed [sum_w-1:0] tap_ext;
        chunk_sum = '0;
        for (int j = 0; j < rx_emu_pkg::chunk_width; j++) begin
            bit_pos = rx_emu_pkg::chunk_width * int'(chunk_idx) + j;
            tap_k   = int'(samp_pt) - bit_pos;
            tap_ext = '0;
            if (tap_k >= 0 && tap_k < rx_emu_pkg::n_taps) begin
                tap_ext = rx_emu_pkg::chan_taps[tap_k];  // sign extended
            end
            if (chunk[j]) begin
                chunk_sum = chunk_sum + tap_ext;  // symbol +1
            end else begin
                chunk_sum = chunk_sum - tap_ext;  // symbol -1
            end
        end
    end

    // chunk0 restarts the sum, settle and write hold it
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            acc <= '0;
        end else if (acc_en) begin
            if (chunk_idx == '0) begin
                acc <= chunk_sum;
            end else begin
                acc <= acc + chunk_sum;
            end
        end
    end

    assign abs_sum = acc[sum_w-1] ? sum_w'(-acc) : sum_w'(acc);

    // sign / magnitude split, held until the next frame end
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            out_sgn <= 1'b0;
            out_mag <= '0;
        end else if (frame_end) begin
            out_sgn <= acc[sum_w-1];
            out_mag <= abs_sum[rx_emu_pkg::adc_width-1:0];  // no clipping needed
        end
    end

    // tap table keeps |sum| <= 188, magnitude field is 8 bits
    a_mag_in_range: assert property (
        @(posedge emu_clk) disable iff (emu_rst)
        frame_end |-> (abs_sum < sum_w'(256))
    );

endmodule

//--- hdl/rx_emu_top.sv
`timescale 1ns/1ns

module rx_emu_top (
    input  logic                                  emu_clk,
    input  logic                                  emu_rst,
    input  logic [rx_emu_pkg::hist_width/2-1:0]   rx_bits,    // new received bits, one word a frame
    input  logic [rx_emu_pkg::pi_width-1:0]       ctl_pi [rx_emu_pkg::n_pi_groups],
    input  logic                                  ctl_valid,
    output logic                                  adc_valid,  // one cycle per frame
    output logic [rx_emu_pkg::adc_width-1:0]      adder_out [rx_emu_pkg::n_slices],
    output logic [rx_emu_pkg::n_slices-1:0]       sign_out
);

    logic [$clog2(rx_emu_pkg::n_chunks)-1:0] chunk_idx;
    logic                                    acc_en;
    logic                                    frame_end;
    logic [rx_emu_pkg::chunk_width-1:0]      chunk;
    logic [rx_emu_pkg::pi_width-1:0]         pi_code [rx_emu_pkg::n_pi_groups];  // active codes

    frame_sequencer seq_i (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .ctl_valid (ctl_valid),
        .ctl_pi    (ctl_pi),
        .chunk_idx (chunk_idx),
        .acc_en    (acc_en),
        .frame_end (frame_end),
        .pi_code   (pi_code)
    );

    bit_history hist_i (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .rx_bits   (rx_bits),
        .frame_end (frame_end),
        .chunk_idx (chunk_idx),
        .chunk     (chunk)
    );

    // all slices see the same chunk, each picks its own window
    for (genvar i = 0; i < rx_emu_pkg::n_slices; i++) begin : g_slice
        adc_slice slice_i (
            .emu_clk   (emu_clk),
            .emu_rst   (emu_rst),
            .chunk     (chunk),
            .chunk_idx (chunk_idx),
            .acc_en    (acc_en),
            .frame_end (frame_end),
            .pi_code   (pi_code[i / rx_emu_pkg::n_lanes]),  // four slices per code
            .slice_idx (4'(i)),
            .out_sgn   (sign_out[i]),
            .out_mag   (adder_out[i])
        );
    end

    // valid lines up with the slice output registers
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            adc_valid <= 1'b0;
        end else begin
            adc_valid <= frame_end;
        end
    end

endmodule

//--- tb/rx_emu_model.svh
`ifndef RX_EMU_MODEL_SVH
`define RX_EMU_MODEL_SVH

// sample point of a slice from p = 16 + i - d
function automatic int sample_point(
    input int                              slice,
    input logic [rx_emu_pkg::pi_width-1:0] pi
);
    int dly;
    dly = int'(pi[rx_emu_pkg::pi_delay_lsb +: 2]);
    return rx_emu_pkg::hist_width / 2 + slice - dly;
endfunction

// signed isi sum seen by one slice over a full history
function automatic int isi_sum(
    input logic [rx_emu_pkg::hist_width-1:0] hist,
    input int                                slice,
    input logic [rx_emu_pkg::pi_width-1:0]   pi
);
    int p;
    int total;
    p     = sample_point(slice, pi);
    total = 0;
    for (int k = 0; k < rx_emu_pkg::n_taps; k++) begin
        if (hist[p - k]) begin
            total = total + int'(rx_emu_pkg::chan_taps[k]);  // symbol +1
        end else begin
            total = total - int'(rx_emu_pkg::chan_taps[k]);  // symbol -1
        end
    end
    return total;
endfunction

// expected sign_out bit is 1 for a negative sum
function automatic logic sign_of(input int sum);
    return (sum < 0);
endfunction

// expected adder_out value
function automatic logic [rx_emu_pkg::adc_width-1:0] magnitude_of(input int sum);
    int mag;
    mag = (sum < 0) ? -sum : sum;
    return rx_emu_pkg::adc_width'(mag);
endfunction

`endif

//--- tb/rx_emu_tb.sv
`timescale 1ns/1ns

module rx_emu_tb;

    localparam int n_rows     = 52;  // 10 fixed, 40 random, 2 trailing fillers
    localparam int n_head     = 10;
    localparam int frame_len  = 6;   // cycles between adc_valid pulses
    localparam int wait_limit = 20;

    logic                                  emu_clk;
    logic                                  emu_rst;
    logic [rx_emu_pkg::hist_width/2-1:0]   rx_bits;
    logic [rx_emu_pkg::pi_width-1:0]       ctl_pi [rx_emu_pkg::n_pi_groups];
    logic                                  ctl_valid;
    logic                                  adc_valid;
    logic [rx_emu_pkg::adc_width-1:0]      adder_out [rx_emu_pkg::n_slices];
    logic [rx_emu_pkg::n_slices-1:0]       sign_out;

    // stimulus table, one row per frame
    logic [15:0] tbl_bits   [n_rows];
    logic [8:0]  tbl_pi     [n_rows][4];
    logic        tbl_load   [n_rows];  // pulse ctl_valid with this row
    int          tbl_expect [n_rows];  // hand sum for every slice or 0 for the model

    // model copy of the history and the pi commit rule
    logic [31:0] m_hist;
    logic [8:0]  m_shadow [4];
    logic [8:0]  m_active [4];
    logic [15:0] applied_bits;  // word the next write edge loads

    int cyc;
    int last_pulse;
    int err_cnt;
    int frame_errs;
    int frames_ok;
    int frames_bad;
    bit timed_out;
    bit found;

    `include "rx_emu_model.svh"

    rx_emu_top dut_i (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .rx_bits   (rx_bits),
        .ctl_pi    (ctl_pi),
        .ctl_valid (ctl_valid),
        .adc_valid (adc_valid),
        .adder_out (adder_out),
        .sign_out  (sign_out)
    );

    always #4 emu_clk = ~emu_clk;

    always @(posedge emu_clk) cyc <= cyc + 1;  // edge counter for pulse spacing

    task automatic count_error();
        err_cnt++;
        frame_errs++;
    endtask

    task automatic set_row(input int r, input logic [15:0] bits, input logic [8:0] c0,
                           input logic [8:0] c1, input logic [8:0] c2, input logic [8:0] c3,
                           input logic load, input int exp_sum);
        tbl_bits[r]   = bits;
        tbl_pi[r][0]  = c0;
        tbl_pi[r][1]  = c1;
        tbl_pi[r][2]  = c2;
        tbl_pi[r][3]  = c3;
        tbl_load[r]   = load;
        tbl_expect[r] = exp_sum;
    endtask

    task automatic fill_table();
        set_row(0, 16'hFFFF, 9'h000, 9'h000, 9'h000, 9'h000, 1'b0, -126);  // reset history
        set_row(1, 16'hFFFF, 9'h000, 9'h000, 9'h000, 9'h000, 1'b0, -126);
        set_row(2, 16'h0000, 9'h000, 9'h000, 9'h000, 9'h000, 1'b0, 0);  // ones over zeros
        set_row(3, 16'h0000, 9'h000, 9'h000, 9'h000, 9'h000, 1'b0, 126);  // all ones
        set_row(4, 16'hAAAA, 9'h000, 9'h000, 9'h000, 9'h000, 1'b0, 0);
        set_row(5, 16'hAAAA, 9'h000, 9'h000, 9'h000, 9'h000, 1'b0, -126);  // all zeros
        set_row(6, 16'h5555, 9'h035, 9'h0C3, 9'h15A, 9'h1FF, 1'b1, 0);  // delays 0,1,2,3
        set_row(7, 16'hC3A5, 9'h035, 9'h0C3, 9'h15A, 9'h1FF, 1'b0, 0);
        set_row(8, 16'h0F0F, 9'h180, 9'h100, 9'h0A0, 9'h07F, 1'b1, 0);  // reversed delays
        set_row(9, 16'h1234, 9'h1C0, 9'h1C0, 9'h1C0, 9'h1C0, 1'b0, 0);  // no strobe so ignored
        for (int r = n_head; r < n_rows - 2; r++) begin
            tbl_bits[r] = 16'($urandom);
            for (int g = 0; g < 4; g++) tbl_pi[r][g] = 9'($urandom);
            tbl_load[r]   = 1'($urandom);
            tbl_expect[r] = 0;
        end
        set_row(n_rows - 2, 16'hFFFF, 9'h000, 9'h000, 9'h000, 9'h000, 1'b1, 0);
        set_row(n_rows - 1, 16'h0000, 9'h000, 9'h000, 9'h000, 9'h000, 1'b0, 0);
    endtask

    // outputs stay cleared until the first frame is written
    task automatic check_idle();
        if (adc_valid !== 1'b0) begin
            $display("MISMATCH at %0t ns: adc_valid expected 0, got %0b", $time, adc_valid);
            count_error();
        end
        for (int i = 0; i < rx_emu_pkg::n_slices; i++) begin
            if (sign_out[i] !== 1'b0) begin
                $display("MISMATCH at %0t ns: sign_out[%0d] expected 0, got %0b",
                         $time, i, sign_out[i]);
                count_error();
            end
            if (adder_out[i] !== 8'd0) begin
                $display("MISMATCH at %0t ns: adder_out[%0d] expected 0, got %0d",
                         $time, i, adder_out[i]);
                count_error();
            end
        end
    endtask

    task automatic wait_pulse(input bit idle, output bit seen);
        seen = 1'b0;
        for (int n = 0; n < wait_limit && !seen; n++) begin
            @(negedge emu_clk);
            if (adc_valid === 1'b1) seen = 1'b1;
            else if (idle) check_idle();
        end
    endtask

    task automatic check_frame(input int r);
        int         sum;
        logic       exp_sgn;
        logic [7:0] exp_mag;
        for (int i = 0; i < rx_emu_pkg::n_slices; i++) begin
            if (tbl_expect[r] != 0) sum = tbl_expect[r];  // uniform pattern with a known total
            else sum = isi_sum(m_hist, i, m_active[i / rx_emu_pkg::n_lanes]);
            exp_sgn = sign_of(sum);
            exp_mag = magnitude_of(sum);
            if (sign_out[i] !== exp_sgn) begin
                $display("MISMATCH at %0t ns: sign_out[%0d] expected %0b, got %0b",
                         $time, i, exp_sgn, sign_out[i]);
                count_error();
            end
            if (adder_out[i] !== exp_mag) begin
                $display("MISMATCH at %0t ns: adder_out[%0d] expected %0d, got %0d",
                         $time, i, exp_mag, adder_out[i]);
                count_error();
            end
        end
    endtask

    // new word and codes go out right after the write edge
    task automatic drive_row(input int r);
        @(posedge emu_clk);
        rx_bits   <= tbl_bits[r];
        ctl_valid <= tbl_load[r];
        for (int g = 0; g < 4; g++) ctl_pi[g] <= tbl_pi[r][g];
        applied_bits = tbl_bits[r];
        if (tbl_load[r]) begin
            for (int g = 0; g < 4; g++) m_shadow[g] = tbl_pi[r][g];
        end
        @(negedge emu_clk);
        if (adc_valid !== 1'b0) begin
            $display("adc_valid stayed high for more than one cycle at %0t ns", $time);
            count_error();
        end
        @(posedge emu_clk);
        ctl_valid <= 1'b0;  // one cycle strobe
    endtask

    initial begin
        void'($urandom(29762));
        emu_clk   = 1'b0;
        emu_rst   = 1'b1;
        rx_bits   = '0;
        ctl_valid = 1'b0;
        for (int g = 0; g < 4; g++) begin
            ctl_pi[g]   = '0;
            m_shadow[g] = '0;
            m_active[g] = '0;
        end
        m_hist = '0;
        applied_bits = '0;
        cyc = 0;
        last_pulse = 0;
        err_cnt = 0;
        frames_ok = 0;
        frames_bad = 0;
        timed_out = 1'b0;
        fill_table();
        repeat (5) @(posedge emu_clk);
        emu_rst <= 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            frame_errs = 0;
            wait_pulse(r == 0, found);
            if (!found) begin
                $display("timeout: no adc_valid pulse within %0d cycles in frame %0d",
                         wait_limit, r);
                timed_out = 1'b1;
                break;
            end
            if (r > 0 && cyc - last_pulse != frame_len) begin
                $display("adc_valid pulses %0d cycles apart at %0t ns, expected %0d",
                         cyc - last_pulse, $time, frame_len);
                count_error();
            end
            last_pulse = cyc;
            check_frame(r);
            m_hist = {applied_bits, m_hist[31:16]};  // write edge loads history and commits codes
            for (int g = 0; g < 4; g++) m_active[g] = m_shadow[g];
            drive_row(r);
            if (frame_errs == 0) frames_ok++;
            else frames_bad++;
            $display("frame %0d word %h load %0b: %0d errors", r, tbl_bits[r], tbl_load[r],
                     frame_errs);
        end
        $display("%0d frames ok, %0d frames failed, %0d errors", frames_ok, frames_bad, err_cnt);
        if (err_cnt == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+tb
hdl/rx_emu_pkg.sv
hdl/frame_sequencer.sv
hdl/bit_history.sv
hdl/adc_slice.sv
hdl/rx_emu_top.sv
tb/rx_emu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
TOP       ?= rx_emu_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
